/* all.f */
verilog/lcdPkg.sv
verilog/lcdTextRom.sv
verilog/lcdNibbleWriter.sv
verilog/lcdSequencer.sv
verilog/lcdTop.sv
test/tbClock.sv
test/lcdTb.sv

/* Bender.yml */
package:
  name: lcd_opcode_display

sources:
  - verilog/lcdPkg.sv
  - verilog/lcdTextRom.sv
  - verilog/lcdNibbleWriter.sv
  - verilog/lcdSequencer.sv
  - verilog/lcdTop.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/lcdTb.sv

/* test/lcdTb.sv */
module lcdTb;

	localparam int clkPerUs = 2;
	localparam int numPasses = 4;
	localparam int pulseCycles = 12;
	localparam int textStart = 13; // 4 config bytes then 9 glyph bytes
	localparam int passLen = 34;
	localparam int totalBytes = textStart + numPasses * passLen;
	// power, config, glyph, text passes
	localparam int waitSumUs = (15000 + 4100 + 100 + 40 + 40) + (3 * 40 + 1640) + 9 * 40
		+ numPasses * passLen * 40;
	localparam int numXfers = 5 + 4 + 9 + numPasses * passLen;
	localparam int cycleLimit = 2 * waitSumUs * clkPerUs + 40 * numXfers;

	localparam lcdPkg::opcode_t fallbackOp = lcdPkg::opcode_t'(4'b0100);
	localparam lcdPkg::opcode_t noOpcode = lcdPkg::opcode_t'(4'b1101); // never drawn
	localparam lcdPkg::opcode_t opChoices [11] = '{
		lcdPkg::opAnd, lcdPkg::opOr, lcdPkg::opAdd, lcdPkg::opAddi, lcdPkg::opSub,
		lcdPkg::opSlt, lcdPkg::opLw, lcdPkg::opSw, lcdPkg::opBne, lcdPkg::opJump, fallbackOp
	};
	localparam lcdPkg::lcdByte_t glyph [8] = '{
		8'h0C, 8'h0E, 8'h04, 8'h1F, 8'h04, 8'h0A, 8'h1B, 8'h00
	};

	typedef struct packed {
		logic rs;
		lcdPkg::lcdByte_t value;
	} lcdWord_t;

	logic clk;
	logic rstN;
	lcdPkg::opcode_t opcode;
	lcdPkg::lcdBus_t lcd;

	lcdPkg::lcdBus_t nibbleQ [$];
	lcdPkg::opcode_t passOp [numPasses];
	logic [31:0] rngState;
	int line1Seen = 0;
	int line2Seen = 0;
	int cycleCount = 0;

	tbClock #(
		.period      (100),
		.resetCycles (4)
	) clock_i (
		.clk  (clk),
		.rstN (rstN)
	);

	lcdTop #(
		.clkPerUs (clkPerUs)
	) dut_i (
		.clk    (clk),
		.rstN   (rstN),
		.opcode (opcode),
		.lcd    (lcd)
	);

	//////////////////////////////////////////////////
	// reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic string opName(input lcdPkg::opcode_t op);
		case (op)
		lcdPkg::opAnd: return "And";
		lcdPkg::opOr: return "or";
		lcdPkg::opAdd: return "Add";
		lcdPkg::opAddi: return "Addi";
		lcdPkg::opSub: return "Sub";
		lcdPkg::opSlt: return "SLT";
		lcdPkg::opLw: return "LW";
		lcdPkg::opSw: return "SW";
		lcdPkg::opBne: return "BNE";
		lcdPkg::opJump: return "Jump";
		default: return "Default";
		endcase
	endfunction

	// p runs over both lines from 0 to 31
	function automatic lcdPkg::lcdByte_t textChar(input lcdPkg::opcode_t op, input int p);
		string name;
		name = opName(op);
		if (p < name.len())
			return lcdPkg::lcdByte_t'(name[p]);
		else if (p == name.len())
			return 8'h00;
		else if (p == 16)
			return 8'hFF;
		else
			return 8'h20;
	endfunction

	function automatic lcdPkg::lcdBus_t powerNibble(input int n);
		lcdPkg::lcdBus_t b;
		b = '0;
		b.en = 1'b1;
		b.data = (n == 3) ? 4'h2 : 4'h3;
		return b;
	endfunction

	function automatic lcdWord_t expectedByte(input int index, input lcdPkg::opcode_t op);
		lcdWord_t e;
		int k;
		e = '0;
		k = (index - textStart) % passLen;
		case (index)
		0: e.value = 8'h28;
		1: e.value = 8'h06;
		2: e.value = 8'h0C;
		3: e.value = 8'h01;
		4: e.value = 8'h40; // CGRAM slot 0
		default: begin
			if (index < textStart) begin
				e.rs = 1'b1;
				e.value = glyph[index - 5];
			end else if (k == 0)
				e.value = 8'h80;
			else if (k == 17)
				e.value = 8'hC0;
			else begin
				e.rs = 1'b1;
				e.value = textChar(op, (k < 17) ? k - 1 : k - 2);
			end
		end
		endcase
		return e;
	endfunction

	task automatic drawOpcode(input lcdPkg::opcode_t prev, output lcdPkg::opcode_t op);
		do begin
			rngState = xorshift32(rngState);
			op = opChoices[rngState % 11];
		end while (op == prev);
	endtask

	//////////////////////////////////////////////////
	// checks

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkNibble(input lcdPkg::lcdBus_t got, input lcdPkg::lcdBus_t exp,
			input string what);
		if (got !== exp)
			failNow($sformatf("[FAIL] t=%0t %s: en=%b rs=%b rw=%b data=%h, expected %b %b %b %h",
				$time, what, got.en, got.rs, got.rw, got.data, exp.en, exp.rs, exp.rw, exp.data));
	endtask

	task automatic checkByte(input lcdWord_t got, input lcdWord_t exp, input int index);
		if (got !== exp)
			failNow($sformatf("[FAIL] t=%0t byte %0d: rs=%b value=%h, expected rs=%b value=%h",
				$time, index, got.rs, got.value, exp.rs, exp.value));
	endtask

	task automatic checkPulse(input int highCycles, input bit stable);
		if (highCycles != pulseCycles)
			failNow($sformatf("[FAIL] t=%0t enable high for %0d cycles, expected %0d",
				$time, highCycles, pulseCycles));
		if (!stable)
			failNow($sformatf("[FAIL] t=%0t rs or data changed while enable was high", $time));
	endtask

	//////////////////////////////////////////////////
	// bus decoder on the falling clock edge

	lcdPkg::lcdBus_t pulseBus;
	int highCycles;
	bit dataStable;
	bit prevEn = 1'b0;

	always @(negedge clk) begin
		if (rstN === 1'b1) begin
			if (lcd.rw !== 1'b0)
				failNow($sformatf("[FAIL] t=%0t read/write line is not low", $time));
			if (lcd.en === 1'b1) begin
				if (!prevEn) begin
					pulseBus = lcd;
					highCycles = 1;
					dataStable = 1'b1;
				end else begin
					highCycles++;
					if (lcd.rs !== pulseBus.rs || lcd.data !== pulseBus.data)
						dataStable = 1'b0;
				end
			end else if (prevEn) begin // falling edge of enable
				checkPulse(highCycles, dataStable);
				nibbleQ.push_back(pulseBus);
			end
			prevEn = (lcd.en === 1'b1);
		end
	end

	// timeout
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
			failNow($sformatf("Timeout: the display sequence did not finish in %0d cycles",
				cycleLimit));
	end

	//////////////////////////////////////////////////
	// stimulus

	initial begin
		lcdPkg::opcode_t next;
		lcdPkg::opcode_t other;
		rngState = 32'd52780;
		drawOpcode(noOpcode, next);
		passOp[0] = next;
		opcode = next;
		@(negedge clk);
		while (rstN !== 1'b1) @(negedge clk);
		checkNibble(lcd, '0, "bus after reset");
		for (int p = 0; p < numPasses; p++) begin
			while (line1Seen <= p) @(negedge clk);
			// live input moves while line 1 still shows the latched opcode
			drawOpcode(passOp[p], other);
			@(posedge clk);
			opcode <= other;
			if (p + 1 < numPasses) begin
				while (line2Seen <= p) @(negedge clk);
				// one pass always shows the undefined encoding
				if (p + 1 == 2 && passOp[p] != fallbackOp)
					next = fallbackOp;
				else
					drawOpcode(passOp[p], next);
				passOp[p + 1] = next;
				@(posedge clk);
				opcode <= next;
			end
		end
	end

	// pairs nibbles into bytes and compares with the reference
	initial begin
		lcdPkg::lcdBus_t hi;
		lcdPkg::lcdBus_t lo;
		lcdWord_t got;
		int passIdx;
		for (int n = 0; n < 4; n++) begin
			while (nibbleQ.size() < 1) @(posedge clk);
			hi = nibbleQ.pop_front();
			checkNibble(hi, powerNibble(n), $sformatf("power nibble %0d", n));
		end
		for (int b = 0; b < totalBytes; b++) begin
			while (nibbleQ.size() < 2) @(posedge clk);
			hi = nibbleQ.pop_front();
			lo = nibbleQ.pop_front();
			if (lo.rs !== hi.rs)
				failNow($sformatf("[FAIL] t=%0t byte %0d: rs differs between nibbles",
					$time, b));
			got.rs = hi.rs;
			got.value = {hi.data, lo.data};
			passIdx = (b < textStart) ? 0 : (b - textStart) / passLen;
			checkByte(got, expectedByte(b, passOp[passIdx]), b);
			if (got.rs == 1'b0 && got.value == 8'h80)
				line1Seen++;
			if (got.rs == 1'b0 && got.value == 8'hC0)
				line2Seen++;
		end
		if (nibbleQ.size() == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else
			failNow($sformatf("[FAIL] t=%0t %0d stray nibbles after the last pass",
				$time, nibbleQ.size()));
	end

endmodule

/* test/tbClock.sv */
module tbClock #(
	parameter int period = 100,
	parameter int resetCycles = 4
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

/* verilog/lcdTop.sv */
module lcdTop #(
	parameter int clkPerUs = 50
) (
	input  logic clk,
	input  logic rstN,
	input  lcdPkg::opcode_t opcode,
	output lcdPkg::lcdBus_t lcd
);

	lcdPkg::lcdXfer_t xfer;
	logic xferValid;
	logic xferReady;
	lcdPkg::opcode_t romOpcode;
	logic [lcdPkg::posW-1:0] romPos;
	lcdPkg::lcdByte_t romChar;

	lcdSequencer sequencer_i (
		.clk       (clk),
		.rstN      (rstN),
		.opcode    (opcode),
		.xfer      (xfer),
		.xferValid (xferValid),
		.xferReady (xferReady),
		.romOpcode (romOpcode),
		.romPos    (romPos),
		.romChar   (romChar)
	);

	lcdNibbleWriter #(
		.clkPerUs (clkPerUs)
	) writer_i (
		.clk       (clk),
		.rstN      (rstN),
		.xfer      (xfer),
		.xferValid (xferValid),
		.xferReady (xferReady),
		.lcd       (lcd)
	);

	lcdTextRom textRom_i (
		.opcode   (romOpcode),
		.pos      (romPos),
		.charCode (romChar)
	);

endmodule

/* verilog/lcdSequencer.sv */
module lcdSequencer (
	input  logic clk,
	input  logic rstN,
	input  lcdPkg::opcode_t opcode,
	output lcdPkg::lcdXfer_t xfer,
	output logic xferValid,
	input  logic xferReady,
	output lcdPkg::opcode_t romOpcode,
	output logic [lcdPkg::posW-1:0] romPos,
	input  lcdPkg::lcdByte_t romChar
);

	typedef enum logic [1:0] {
		phPower,
		phConfig,
		phGlyph,
		phText
	} phase_t;

	localparam logic [5:0] lastPower = 6'd4;
	localparam logic [5:0] lastConfig = 6'd3;
	localparam logic [5:0] lastGlyph = 6'd8;
	localparam logic [5:0] line2Step = 6'(lcdPkg::lineLen + 1);
	localparam logic [5:0] lastText = 6'(2 * lcdPkg::lineLen + 1);

	phase_t phase;
	logic [5:0] step;
	logic [5:0] lastStep;
	logic [5:0] posFull;
	logic [2:0] glyphIdx;
	logic accept;
	logic issue;

	assign accept = xferValid && xferReady;
	assign issue = !xferValid && xferReady; // writer idle, nothing offered yet

	always_comb begin
		case (phase)
		phPower: lastStep = lastPower;
		phConfig: lastStep = lastConfig;
		phGlyph: lastStep = lastGlyph;
		default: lastStep = lastText;
		endcase
	end

	// text steps skip the two address commands
	assign posFull = (step <= 6'(lcdPkg::lineLen)) ? step - 6'd1 : step - 6'd2;
	assign romPos = posFull[lcdPkg::posW-1:0];
	assign glyphIdx = 3'(step - 6'd1);

	//////////////////////////////////////////////////
	// transfer for the current step

	always_comb begin
		xfer = '0;
		xfer.waitUs = lcdPkg::wCmd;
		case (phase)
		phPower: begin
			xfer.nibbleOnly = 1'b1;
			case (step)
			6'd0: begin
				xfer.idle = 1'b1; // power-up wait only
				xfer.waitUs = lcdPkg::wPowerUp;
			end
			6'd1: begin
				xfer.value = 8'h30;
				xfer.waitUs = lcdPkg::wInit1;
			end
			6'd2: begin
				xfer.value = 8'h30;
				xfer.waitUs = lcdPkg::wInit2;
			end
			6'd3: xfer.value = 8'h30;
			default: xfer.value = 8'h20; // switch to 4-bit
			endcase
		end
		phConfig: begin
			case (step)
			6'd0: xfer.value = lcdPkg::cmdFunctionSet;
			6'd1: xfer.value = lcdPkg::cmdEntryMode;
			6'd2: xfer.value = lcdPkg::cmdDisplayOn;
			default: begin
				xfer.value = lcdPkg::cmdClear;
				xfer.waitUs = lcdPkg::wClear;
			end
			endcase
		end
		phGlyph: begin
			if (step == 6'd0)
				xfer.value = lcdPkg::cmdCgramBase;
			else begin
				xfer.rs = 1'b1;
				xfer.value = lcdPkg::glyphRows[glyphIdx];
				xfer.waitUs = lcdPkg::wChar;
			end
		end
		default: begin
			if (step == 6'd0)
				xfer.value = lcdPkg::cmdLine1;
			else if (step == line2Step)
				xfer.value = lcdPkg::cmdLine2;
			else begin
				xfer.rs = 1'b1;
				xfer.value = romChar;
				xfer.waitUs = lcdPkg::wChar;
			end
		end
		endcase
	end

	//////////////////////////////////////////////////
	// phase and step

	always_ff @(posedge clk) begin
		if (!rstN) begin
			phase <= phPower;
			step <= '0;
			xferValid <= 1'b0;
		end else if (accept) begin
			xferValid <= 1'b0;
			if (step == lastStep) begin
				step <= '0;
				if (phase != phText)
					phase <= phase_t'(phase + 2'd1);
			end else
				step <= step + 6'd1;
		end else if (issue)
			xferValid <= 1'b1;
	end

	// opcode held for a whole pass
	always_ff @(posedge clk) begin
		if (issue && phase == phText && step == 6'd0)
			romOpcode <= opcode;
	end

endmodule

/* verilog/lcdNibbleWriter.sv */
module lcdNibbleWriter #(
	parameter int clkPerUs = 50
) (
	input  logic clk,
	input  logic rstN,
	input  lcdPkg::lcdXfer_t xfer,
	input  logic xferValid,
	output logic xferReady,
	output lcdPkg::lcdBus_t lcd
);

	localparam int preW = $clog2(clkPerUs + 1);
	localparam logic [preW-1:0] preMax = preW'(clkPerUs - 1);
	localparam logic [15:0] setupCnt = 16'(lcdPkg::tSetup - 1);
	localparam logic [15:0] enableCnt = 16'(lcdPkg::tEnable - 1);
	localparam logic [15:0] holdCnt = 16'(lcdPkg::tHold - 1);

	typedef enum logic [2:0] {
		sIdle,
		sSetup,
		sEnable,
		sHold,
		sGap,
		sSettle
	} state_t;

	state_t state;
	lcdPkg::lcdXfer_t cur;
	logic lowNibble;
	logic [15:0] cnt;     // cycles in the pulse, microseconds in the waits
	logic [preW-1:0] pre;
	logic accept;
	logic tick;
	logic usDone;

	assign xferReady = (state == sIdle);
	assign accept = xferValid && xferReady;
	assign tick = (pre == preMax);
	// last cycle of a microsecond wait
	assign usDone = (cnt == 16'd0) || (cnt == 16'd1 && tick);

	always_ff @(posedge clk) begin
		if (accept)
			cur <= xfer;
	end

	// prescaler, only runs in gap and settle
	always_ff @(posedge clk) begin
		if (!rstN || (state != sGap && state != sSettle))
			pre <= '0;
		else if (tick)
			pre <= '0;
		else
			pre <= pre + 1'b1;
	end

	//////////////////////////////////////////////////
	// pulse FSM

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= sIdle;
			lowNibble <= 1'b0;
			cnt <= '0;
			lcd <= '0;
		end else begin
			lcd.rw <= 1'b0; // never read back
			case (state)
			sIdle: begin
				if (accept) begin
					lowNibble <= 1'b0;
					if (xfer.idle) begin
						cnt <= xfer.waitUs;
						state <= sSettle;
					end else begin
						lcd.rs <= xfer.rs;
						lcd.data <= xfer.value[7:4];
						cnt <= setupCnt;
						state <= sSetup;
					end
				end
			end
			sSetup: begin
				if (cnt == 16'd0) begin
					lcd.en <= 1'b1;
					cnt <= enableCnt;
					state <= sEnable;
				end else
					cnt <= cnt - 1'b1;
			end
			sEnable: begin
				if (cnt == 16'd0) begin
					lcd.en <= 1'b0; // data latched by display here
					cnt <= holdCnt;
					state <= sHold;
				end else
					cnt <= cnt - 1'b1;
			end
			sHold: begin
				if (cnt == 16'd0) begin
					if (!cur.nibbleOnly && !lowNibble) begin
						cnt <= lcdPkg::wNibbleGap;
						state <= sGap;
					end else begin
						cnt <= cur.waitUs;
						state <= sSettle;
					end
				end else
					cnt <= cnt - 1'b1;
			end
			sGap: begin
				if (usDone) begin
					lowNibble <= 1'b1;
					lcd.data <= cur.value[3:0];
					cnt <= setupCnt;
					state <= sSetup;
				end else if (tick)
					cnt <= cnt - 1'b1;
			end
			sSettle: begin
				if (usDone)
					state <= sIdle;
				else if (tick)
					cnt <= cnt - 1'b1;
			end
			default: state <= sIdle;
			endcase
		end
	end

endmodule

/* verilog/lcdTextRom.sv */
module lcdTextRom (
	input  lcdPkg::opcode_t opcode,
	input  logic [lcdPkg::posW-1:0] pos,
	output lcdPkg::lcdByte_t charCode
);

	logic [8*7-1:0] name; // right aligned, first letter on top
	logic [2:0] nameLen;
	logic [2:0] idx;

	always_comb begin
		case (opcode)
		lcdPkg::opAnd: begin
			name = "And";
			nameLen = 3'd3;
		end
		lcdPkg::opOr: begin
			name = "or";
			nameLen = 3'd2;
		end
		lcdPkg::opAdd: begin
			name = "Add";
			nameLen = 3'd3;
		end
		lcdPkg::opAddi: begin
			name = "Addi";
			nameLen = 3'd4;
		end
		lcdPkg::opSub: begin
			name = "Sub";
			nameLen = 3'd3;
		end
		lcdPkg::opSlt: begin
			name = "SLT";
			nameLen = 3'd3;
		end
		lcdPkg::opLw: begin
			name = "LW";
			nameLen = 3'd2;
		end
		lcdPkg::opSw: begin
			name = "SW";
			nameLen = 3'd2;
		end
		lcdPkg::opBne: begin
			name = "BNE";
			nameLen = 3'd3;
		end
		lcdPkg::opJump: begin
			name = "Jump";
			nameLen = 3'd4;
		end
		default: begin // undefined encodings
			name = "Default";
			nameLen = 3'd7;
		end
		endcase
	end

	assign idx = nameLen - 3'd1 - pos[2:0];

	always_comb begin
		if (pos < nameLen)
			charCode = name[{idx, 3'b000} +: 8];
		else if (pos == nameLen)
			charCode = lcdPkg::chGlyph0; // terminator glyph
		else if (pos == lcdPkg::lineLen)
			charCode = lcdPkg::chBlock; // first cell of line 2
		else
			charCode = lcdPkg::chSpace;
	end

endmodule

/* verilog/lcdPkg.sv */
package lcdPkg;

	//////////////////////////////////////////////////
	// bus and transfer types

	typedef logic [7:0] lcdByte_t;

	// pins of the 4-bit display bus
	typedef struct packed {
		logic en;
		logic rs;
		logic rw;
		logic [3:0] data;
	} lcdBus_t;

	// one request from sequencer to nibble writer
	typedef struct packed {
		logic rs;           // 0 command, 1 character
		lcdByte_t value;
		logic nibbleOnly;   // upper nibble only, power-on
		logic idle;         // no pulse at all, settle wait only
		logic [15:0] waitUs;
	} lcdXfer_t;

	typedef enum logic [3:0] {
		opAnd  = 4'b0000,
		opOr   = 4'b0001,
		opAdd  = 4'b0010,
		opAddi = 4'b0011,
		opSub  = 4'b0110,
		opSlt  = 4'b0111,
		opLw   = 4'b1000,
		opSw   = 4'b1010,
		opBne  = 4'b1110,
		opJump = 4'b1111
	} opcode_t;

	//////////////////////////////////////////////////
	// timing

	// enable pulse, in clock cycles
	localparam int tSetup = 2;
	localparam int tEnable = 12;
	localparam int tHold = 2;

	// settle waits, in microseconds
	localparam logic [15:0] wPowerUp = 16'd15000;
	localparam logic [15:0] wInit1 = 16'd4100;
	localparam logic [15:0] wInit2 = 16'd100;
	localparam logic [15:0] wCmd = 16'd40;
	localparam logic [15:0] wClear = 16'd1640;
	localparam logic [15:0] wChar = 16'd40;
	localparam logic [15:0] wNibbleGap = 16'd1;

	//////////////////////////////////////////////////
	// display commands and characters

	localparam lcdByte_t cmdFunctionSet = 8'h28; // 4-bit, 2 lines, 5x8
	localparam lcdByte_t cmdEntryMode = 8'h06;
	localparam lcdByte_t cmdDisplayOn = 8'h0C;
	localparam lcdByte_t cmdClear = 8'h01;
	localparam lcdByte_t cmdCgramBase = 8'h40;
	localparam lcdByte_t cmdLine1 = 8'h80;
	localparam lcdByte_t cmdLine2 = 8'hC0;

	localparam lcdByte_t chSpace = 8'h20;
	localparam lcdByte_t chBlock = 8'hFF;
	localparam lcdByte_t chGlyph0 = 8'h00;

	// little figure, top row first
	localparam lcdByte_t glyphRows [8] = '{
		8'h0C, 8'h0E, 8'h04, 8'h1F, 8'h04, 8'h0A, 8'h1B, 8'h00
	};

	localparam int lineLen = 16;
	localparam int posW = 5; // two lines of 16

endpackage
